// ==== hdl/mandel_pkg.sv ====
/* Shared defaults and controller state of the fixed-point Mandelbrot renderer
   Modules import it in their bodies and use scoped names in their headers */
package mandel_pkg;

   // Fixed-point format, two's complement
   localparam int DEF_WIDTH = 20;     // Total word width
   localparam int DEF_FRAC  = 10;     // Fractional bits

   // Iteration limit, must fit the pixel
   localparam int DEF_MAX_ITER = 255;

   // Default image size
   localparam int DEF_IMG_W = 16;
   localparam int DEF_IMG_H = 12;

   localparam int PIX_BITS = 8;       // Pixel holds the iteration count

   // Frame controller states
   typedef enum logic [1:0] {
      S_IDLE,                         // Waiting for start
      S_ITER,                         // Pixel being iterated
      S_EMIT                          // Finished pixel on the output
   } render_state_t;

endpackage

// ==== hdl/mandel_top.sv ====
/* Top level of the Mandelbrot renderer, one pixel strobe per image point
   Wires the frame controller, the raster counter and the pixel iterator */
`timescale 1ns/1ps

module mandel_top #(
   parameter int WIDTH    = mandel_pkg::DEF_WIDTH,
   parameter int FRAC     = mandel_pkg::DEF_FRAC,
   parameter int MAX_ITER = mandel_pkg::DEF_MAX_ITER,
   parameter int IMG_W    = mandel_pkg::DEF_IMG_W,
   parameter int IMG_H    = mandel_pkg::DEF_IMG_H
) (
   input  logic                            clk,
   input  logic                            n_rst,
   input  logic                            start,
   input  logic signed [WIDTH-1:0]         c_re_origin,
   input  logic signed [WIDTH-1:0]         c_im_origin,
   input  logic signed [WIDTH-1:0]         c_step,
   output logic                            busy,
   output logic                            pixel_valid,
   output logic [mandel_pkg::PIX_BITS-1:0] pixel,
   output logic [$clog2(IMG_W)-1:0]        pixel_x,
   output logic [$clog2(IMG_H)-1:0]        pixel_y,
   output logic                            frame_done
);

   import mandel_pkg::*;

   logic                     clear;
   logic                     advance;
   logic                     calc_start;
   logic                     calc_done;
   logic [PIX_BITS-1:0]      calc_pixel;   // Count straight from the iterator
   logic [$clog2(IMG_W)-1:0] cur_x;        // Live raster position
   logic [$clog2(IMG_H)-1:0] cur_y;
   logic signed [WIDTH-1:0]  c_re;
   logic signed [WIDTH-1:0]  c_im;
   logic                     last_pixel;

   render_fsm #(
      .IMG_W (IMG_W),
      .IMG_H (IMG_H)
   ) i_render_fsm (
      .clk         (clk),
      .n_rst       (n_rst),
      .start       (start),
      .calc_done   (calc_done),
      .last_pixel  (last_pixel),
      .pixel       (calc_pixel),
      .pixel_x     (cur_x),
      .pixel_y     (cur_y),
      .clear       (clear),
      .advance     (advance),
      .calc_start  (calc_start),
      .busy        (busy),
      .pixel_valid (pixel_valid),
      .pixel_out   (pixel),
      .pixel_x_out (pixel_x),
      .pixel_y_out (pixel_y),
      .frame_done  (frame_done)
   );

   scan_counter #(
      .WIDTH (WIDTH),
      .IMG_W (IMG_W),
      .IMG_H (IMG_H)
   ) i_scan_counter (
      .clk         (clk),
      .n_rst       (n_rst),
      .clear       (clear),
      .advance     (advance),
      .c_re_origin (c_re_origin),
      .c_im_origin (c_im_origin),
      .c_step      (c_step),
      .pixel_x     (cur_x),
      .pixel_y     (cur_y),
      .c_re        (c_re),
      .c_im        (c_im),
      .last_pixel  (last_pixel)
   );

   pixel_calculator #(
      .WIDTH    (WIDTH),
      .FRAC     (FRAC),
      .MAX_ITER (MAX_ITER)
   ) i_pixel_calculator (
      .clk        (clk),
      .n_rst      (n_rst),
      .calc_start (calc_start),
      .c_re       (c_re),
      .c_im       (c_im),
      .calc_done  (calc_done),
      .pixel      (calc_pixel)
   );

endmodule

// ==== hdl/pixel_calculator.sv ====
/* Iterates one pixel from calc_start until escape or the iteration limit
   Pulses calc_done for one cycle with the count on pixel */
`timescale 1ns/1ps

module pixel_calculator #(
   parameter int WIDTH    = mandel_pkg::DEF_WIDTH,
   parameter int FRAC     = mandel_pkg::DEF_FRAC,
   parameter int MAX_ITER = mandel_pkg::DEF_MAX_ITER
) (
   input  logic                            clk,
   input  logic                            n_rst,
   input  logic                            calc_start,
   input  logic signed [WIDTH-1:0]         c_re,
   input  logic signed [WIDTH-1:0]         c_im,
   output logic                            calc_done,
   output logic [mandel_pkg::PIX_BITS-1:0] pixel
);

   import mandel_pkg::*;

   localparam logic [PIX_BITS-1:0] ITER_LIMIT = PIX_BITS'(MAX_ITER);

   logic signed [WIDTH-1:0] z_re;     // Current z
   logic signed [WIDTH-1:0] z_im;
   logic signed [WIDTH-1:0] c_re_q;   // c held for the whole pixel
   logic signed [WIDTH-1:0] c_im_q;
   logic [PIX_BITS-1:0]     n;        // Steps taken so far
   logic                    running;

   logic signed [WIDTH-1:0] z_re_next;
   logic signed [WIDTH-1:0] z_im_next;
   logic                    escaped;
   logic                    stop;

   z_step #(
      .WIDTH (WIDTH),
      .FRAC  (FRAC)
   ) i_z_step (
      .z_re      (z_re),
      .z_im      (z_im),
      .c_re      (c_re_q),
      .c_im      (c_im_q),
      .z_re_next (z_re_next),
      .z_im_next (z_im_next),
      .escaped   (escaped)
   );

   // Stop decided on registered z and n
   assign stop      = escaped || (n == ITER_LIMIT);
   assign calc_done = running && stop;
   assign pixel     = n;

   always_ff @(posedge clk, negedge n_rst) begin
      if (!n_rst) begin
         running <= 1'b0;
      end else if (calc_start) begin
         running <= 1'b1;
      end else if (calc_done) begin
         running <= 1'b0;             // Single done pulse
      end
   end

   // Datapath, meaningful only while running
   always_ff @(posedge clk) begin
      if (calc_start) begin
         z_re   <= '0;
         z_im   <= '0;
         n      <= '0;
         c_re_q <= c_re;
         c_im_q <= c_im;
      end else if (running && !stop) begin
         z_re <= z_re_next;
         z_im <= z_im_next;
         n    <= n + 1'b1;
      end
   end

   // One done strobe per pixel
   a_done_single : assert property (@(posedge clk) disable iff (!n_rst)
      calc_done |=> !calc_done);

   // Count held at the limit, never past it
   a_n_limit : assert property (@(posedge clk) disable iff (!n_rst)
      (running && (n == ITER_LIMIT)) |=> (!running && (n == ITER_LIMIT)));

endmodule

// ==== hdl/render_fsm.sv ====
/* Frame controller that runs one pixel at a time through the iterator
   Emits each finished pixel with its position and marks the frame end */
`timescale 1ns/1ps

module render_fsm #(
   parameter int IMG_W = mandel_pkg::DEF_IMG_W,
   parameter int IMG_H = mandel_pkg::DEF_IMG_H
) (
   input  logic                            clk,
   input  logic                            n_rst,
   input  logic                            start,
   input  logic                            calc_done,
   input  logic                            last_pixel,
   input  logic [mandel_pkg::PIX_BITS-1:0] pixel,
   input  logic [$clog2(IMG_W)-1:0]        pixel_x,
   input  logic [$clog2(IMG_H)-1:0]        pixel_y,
   output logic                            clear,
   output logic                            advance,
   output logic                            calc_start,
   output logic                            busy,
   output logic                            pixel_valid,
   output logic [mandel_pkg::PIX_BITS-1:0] pixel_out,
   output logic [$clog2(IMG_W)-1:0]        pixel_x_out,
   output logic [$clog2(IMG_H)-1:0]        pixel_y_out,
   output logic                            frame_done
);

   import mandel_pkg::*;

   render_state_t state;
   render_state_t state_next;
   logic          start_ok;          // start accepted, only in idle
   logic          calc_start_q;

   assign start_ok = (state == S_IDLE) && start;

   always_comb begin
      state_next = state;
      case (state)
         S_IDLE:  if (start) state_next = S_ITER;
         S_ITER:  if (calc_done) state_next = S_EMIT;
         S_EMIT:  state_next = last_pixel ? S_IDLE : S_ITER;
         default: state_next = S_IDLE;
      endcase
   end

   always_ff @(posedge clk, negedge n_rst) begin
      if (!n_rst) begin
         state        <= S_IDLE;
         calc_start_q <= 1'b0;
      end else begin
         state        <= state_next;
         // Cycle after clear, or after each non-final emit
         calc_start_q <= start_ok || ((state == S_EMIT) && !last_pixel);
      end
   end

   // Hold the result, the counter moves on during emit
   always_ff @(posedge clk) begin
      if (calc_done) begin
         pixel_out   <= pixel;
         pixel_x_out <= pixel_x;
         pixel_y_out <= pixel_y;
      end
   end

   assign clear       = start_ok;            // Origin sampled on this edge
   assign calc_start  = calc_start_q;
   assign busy        = (state != S_IDLE);
   assign pixel_valid = (state == S_EMIT);
   assign advance     = (state == S_EMIT);
   assign frame_done  = (state == S_EMIT) && last_pixel;

   // New pixel only on entry to S_ITER, never while one is iterating
   a_start_free : assert property (@(posedge clk) disable iff (!n_rst)
      calc_start |-> ((state == S_ITER) && ($past(state) != S_ITER)));

endmodule

// ==== hdl/scan_counter.sv ====
/* Raster position counter that also accumulates the c coordinates
   clear loads the origin, advance steps to the next pixel */
`timescale 1ns/1ps

module scan_counter #(
   parameter int WIDTH = mandel_pkg::DEF_WIDTH,
   parameter int IMG_W = mandel_pkg::DEF_IMG_W,
   parameter int IMG_H = mandel_pkg::DEF_IMG_H
) (
   input  logic                       clk,
   input  logic                       n_rst,
   input  logic                       clear,
   input  logic                       advance,
   input  logic signed [WIDTH-1:0]    c_re_origin,
   input  logic signed [WIDTH-1:0]    c_im_origin,
   input  logic signed [WIDTH-1:0]    c_step,
   output logic [$clog2(IMG_W)-1:0]   pixel_x,
   output logic [$clog2(IMG_H)-1:0]   pixel_y,
   output logic signed [WIDTH-1:0]    c_re,
   output logic signed [WIDTH-1:0]    c_im,
   output logic                       last_pixel
);

   localparam int XW = $clog2(IMG_W);
   localparam int YW = $clog2(IMG_H);

   localparam logic [XW-1:0] X_LAST = XW'(IMG_W - 1);
   localparam logic [YW-1:0] Y_LAST = YW'(IMG_H - 1);

   logic signed [WIDTH-1:0] re_origin;   // Row start for c_re
   logic signed [WIDTH-1:0] step;
   logic                    row_end;

   assign row_end    = (pixel_x == X_LAST);
   assign last_pixel = row_end && (pixel_y == Y_LAST);

   // Position counters
   always_ff @(posedge clk, negedge n_rst) begin
      if (!n_rst) begin
         pixel_x <= '0;
         pixel_y <= '0;
      end else if (clear) begin
         pixel_x <= '0;
         pixel_y <= '0;
      end else if (advance) begin
         if (row_end) begin
            pixel_x <= '0;
            pixel_y <= (pixel_y == Y_LAST) ? '0 : pixel_y + 1'b1;
         end else begin
            pixel_x <= pixel_x + 1'b1;
         end
      end
   end

   // Coordinate accumulators, wrap at WIDTH
   always_ff @(posedge clk) begin
      if (clear) begin
         re_origin <= c_re_origin;
         step      <= c_step;
         c_re      <= c_re_origin;
         c_im      <= c_im_origin;
      end else if (advance) begin
         if (row_end) begin
            c_re <= re_origin;          // Back to left edge
            c_im <= c_im + step;        // Next row
         end else begin
            c_re <= c_re + step;
         end
      end
   end

   // Position stays inside the image across all updates
   a_in_image : assert property (@(posedge clk) disable iff (!n_rst)
      (pixel_x <= X_LAST) && (pixel_y <= Y_LAST));

endmodule

// ==== hdl/z_step.sv ====
/* One combinational Mandelbrot step z*z + c with the |z|^2 > 4 escape test
   Used by the pixel iterator on its registered z and latched c */
`timescale 1ns/1ps

module z_step #(
   parameter int WIDTH = mandel_pkg::DEF_WIDTH,
   parameter int FRAC  = mandel_pkg::DEF_FRAC
) (
   input  logic signed [WIDTH-1:0] z_re,
   input  logic signed [WIDTH-1:0] z_im,
   input  logic signed [WIDTH-1:0] c_re,
   input  logic signed [WIDTH-1:0] c_im,
   output logic signed [WIDTH-1:0] z_re_next,
   output logic signed [WIDTH-1:0] z_im_next,
   output logic                    escaped
);

   // Full product width plus one bit so sums of squares cannot wrap
   localparam int PW = 2 * WIDTH + 1;

   // Four in the squared format, FRAC doubled by the multiply
   localparam logic signed [PW-1:0] FOUR = {{(PW - 1){1'b0}}, 1'b1} << (2 * FRAC + 2);

   logic signed [PW-1:0] zr_sq;       // zr^2
   logic signed [PW-1:0] zi_sq;       // zi^2
   logic signed [PW-1:0] zri_2;       // 2*zr*zi
   logic signed [PW-1:0] mag_sq;      // zr^2 + zi^2
   logic signed [PW-1:0] re_diff;     // zr^2 - zi^2
   logic signed [PW-1:0] re_shift;
   logic signed [PW-1:0] im_shift;

   // Operands sign-extended to PW before the multiply
   assign zr_sq = PW'(z_re) * PW'(z_re);
   assign zi_sq = PW'(z_im) * PW'(z_im);
   assign zri_2 = (PW'(z_re) * PW'(z_im)) <<< 1;   // Doubling is exact at PW

   // Escape test on the untruncated magnitude
   assign mag_sq  = zr_sq + zi_sq;
   assign escaped = (mag_sq > FOUR);

   assign re_diff = zr_sq - zi_sq;

   // Back to FRAC fractional bits, floor rounding
   assign re_shift = re_diff >>> FRAC;
   assign im_shift = zri_2 >>> FRAC;

   // Low WIDTH bits plus c, wraps like the reference model
   assign z_re_next = re_shift[WIDTH-1:0] + c_re;
   assign z_im_next = im_shift[WIDTH-1:0] + c_im;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the renderer testbench with Verilator and runs it
# Exits nonzero on a build error, a simulator error or a failing test

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_mandel -Mdir obj_dir -o sim_mandel \
   -f vlog.f > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "Verilator build failed, see build.log"
   exit 1
fi

./obj_dir/sim_mandel > sim.log 2>&1
if [ $? -ne 0 ]; then
   cat sim.log
   echo "Simulation exited with an error, see sim.log"
   exit 1
fi

cat sim.log
if grep -q "Test failed" sim.log; then
   echo "FAIL"
   exit 1
fi
echo "PASS"
exit 0

// ==== test/tb_mandel.sv ====
/* Self-checking testbench for the Mandelbrot renderer on a small image
   Runs fixed, constant and random frames and compares every pixel strobe */
`timescale 1ns/1ps

module tb_mandel;

   import mandel_pkg::*;

   localparam int WIDTH         = DEF_WIDTH;
   localparam int FRAC          = DEF_FRAC;
   localparam int MAX_ITER      = 255;
   localparam int IMG_W         = 8;
   localparam int IMG_H         = 6;
   localparam int NPIX          = IMG_W * IMG_H;
   localparam int FRAME_TIMEOUT = 20000;   // Worst frame is about 12.4k cycles
   localparam int BUSY_TIMEOUT  = 50;

   // Fixed-point constants, 1.0 = 1024
   localparam logic signed [WIDTH-1:0] ORG_RE   = WIDTH'(-2048);   // -2.0
   localparam logic signed [WIDTH-1:0] ORG_IM   = WIDTH'(-1229);   // -1.2
   localparam logic signed [WIDTH-1:0] STEP     = WIDTH'(410);     // 0.4
   localparam logic signed [WIDTH-1:0] THREE    = WIDTH'(3072);
   localparam logic signed [WIDTH-1:0] ZERO     = '0;

   logic                     clk;
   logic                     n_rst;
   logic                     start;
   logic signed [WIDTH-1:0]  c_re_origin;
   logic signed [WIDTH-1:0]  c_im_origin;
   logic signed [WIDTH-1:0]  c_step;
   logic                     busy;
   logic                     pixel_valid;
   logic [PIX_BITS-1:0]      pixel;
   logic [$clog2(IMG_W)-1:0] pixel_x;
   logic [$clog2(IMG_H)-1:0] pixel_y;
   logic                     frame_done;

   // Frame as started, what the comparator checks against
   logic signed [WIDTH-1:0]  frame_re = '0;
   logic signed [WIDTH-1:0]  frame_im = '0;
   logic signed [WIDTH-1:0]  frame_step = '0;
   int                       fixed_value = -1;   // Same value for all pixels, -1 if not
   logic                     started = 1'b0;
   logic                     timed_out = 1'b0;   // A wait ran out, later frames skipped

   int     exp_x = 0;                          // Expected raster position
   int     exp_y = 0;
   int     pix_seen = 0;
   int     frames_seen = 0;
   int     value_errors = 0;
   int     proto_errors = 0;
   integer seed;

   mandel_top #(
      .WIDTH    (WIDTH),
      .FRAC     (FRAC),
      .MAX_ITER (MAX_ITER),
      .IMG_W    (IMG_W),
      .IMG_H    (IMG_H)
   ) i_dut (
      .clk         (clk),
      .n_rst       (n_rst),
      .start       (start),
      .c_re_origin (c_re_origin),
      .c_im_origin (c_im_origin),
      .c_step      (c_step),
      .busy        (busy),
      .pixel_valid (pixel_valid),
      .pixel       (pixel),
      .pixel_x     (pixel_x),
      .pixel_y     (pixel_y),
      .frame_done  (frame_done)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;          // 20 ns period
   end

   // Iteration count for pixel (x, y), from z = 0 with the same shifts and wrap
   function automatic int ref_pixel(input logic signed [WIDTH-1:0] re0,
                                    input logic signed [WIDTH-1:0] im0,
                                    input logic signed [WIDTH-1:0] step,
                                    input int x,
                                    input int y);
      longint                  acc;
      longint                  zr2;
      longint                  zi2;
      longint                  re_t;
      longint                  im_t;
      logic signed [WIDTH-1:0] cr;
      logic signed [WIDTH-1:0] ci;
      logic signed [WIDTH-1:0] zr;
      logic signed [WIDTH-1:0] zi;
      int                      n;
      logic                    done;
      acc  = longint'(re0) + longint'(x) * longint'(step);
      cr   = acc[WIDTH-1:0];           // c wraps at WIDTH
      acc  = longint'(im0) + longint'(y) * longint'(step);
      ci   = acc[WIDTH-1:0];
      zr   = '0;
      zi   = '0;
      n    = 0;
      done = 1'b0;
      while (!done) begin
         zr2 = longint'(zr) * longint'(zr);
         zi2 = longint'(zi) * longint'(zi);
         if (((zr2 + zi2) > (longint'(4) << (2 * FRAC))) || (n == MAX_ITER)) begin
            done = 1'b1;               // Escaped or limit reached
         end else begin
            re_t = (zr2 - zi2) >>> FRAC;
            im_t = (longint'(2) * longint'(zr) * longint'(zi)) >>> FRAC;
            zr   = re_t[WIDTH-1:0] + cr;
            zi   = im_t[WIDTH-1:0] + ci;
            n    = n + 1;
         end
      end
      return n;
   endfunction

   // Compares every pixel strobe, outputs are read before the edge updates them
   always @(posedge clk) begin : compare
      logic [PIX_BITS-1:0] exp_pix;
      logic                last_pos;
      if (n_rst && !started && (busy || pixel_valid || frame_done)) begin
         $display("ERROR at %0t: renderer active before the first start", $time);
         proto_errors++;
      end
      last_pos = (exp_x == IMG_W - 1) && (exp_y == IMG_H - 1);
      if (frame_done && !pixel_valid) begin
         $display("ERROR at %0t: frame_done without pixel_valid", $time);
         proto_errors++;
      end
      if (pixel_valid) begin
         exp_pix = PIX_BITS'(ref_pixel(frame_re, frame_im, frame_step, exp_x, exp_y));
         if (pixel != exp_pix) begin
            $display("ERROR at %0t: pixel (%0d,%0d) is %0d, expected %0d",
                     $time, exp_x, exp_y, pixel, exp_pix);
            value_errors++;
         end
         if ((fixed_value >= 0) && (int'(pixel) != fixed_value)) begin
            $display("ERROR at %0t: pixel (%0d,%0d) is %0d, expected constant %0d",
                     $time, exp_x, exp_y, pixel, fixed_value);
            value_errors++;
         end
         if ((int'(pixel_x) != exp_x) || (int'(pixel_y) != exp_y)) begin
            $display("ERROR at %0t: position (%0d,%0d), expected (%0d,%0d)",
                     $time, pixel_x, pixel_y, exp_x, exp_y);
            value_errors++;
         end
         if (frame_done != last_pos) begin
            $display("ERROR at %0t: frame_done is %0b at pixel (%0d,%0d)",
                     $time, frame_done, exp_x, exp_y);
            proto_errors++;
         end
         pix_seen++;
         exp_x++;                      // Raster order, wraps to the next frame
         if (exp_x == IMG_W) begin
            exp_x = 0;
            exp_y = (exp_y == IMG_H - 1) ? 0 : exp_y + 1;
         end
      end
      if (frame_done) frames_seen++;
   end

   // A wait that ran out ends the run as failed
   task automatic note_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      timed_out = 1'b1;
   endtask

   // One frame from start to frame_done, with optional start strobes while busy
   task automatic run_frame(input logic signed [WIDTH-1:0] re0,
                            input logic signed [WIDTH-1:0] im0,
                            input logic signed [WIDTH-1:0] step,
                            input int expect_value,
                            input int extra_starts);
      int pix_before;
      int frames_before;
      int cycles;
      int pulses;
      if (timed_out) return;
      @(negedge clk);
      frame_re      = re0;
      frame_im      = im0;
      frame_step    = step;
      fixed_value   = expect_value;
      c_re_origin   = re0;
      c_im_origin   = im0;
      c_step        = step;
      pix_before    = pix_seen;
      frames_before = frames_seen;
      start         = 1'b1;
      started       = 1'b1;
      @(negedge clk);
      start  = 1'b0;
      cycles = 0;
      pulses = 0;
      while ((frames_seen == frames_before) && (cycles < FRAME_TIMEOUT)) begin
         @(negedge clk);
         cycles++;
         start = 1'b0;
         if ((pulses < extra_starts) && busy && (cycles % 37 == 3)) begin
            c_re_origin = WIDTH'($random(seed));   // Junk, must not be sampled
            c_im_origin = WIDTH'($random(seed));
            c_step      = WIDTH'($random(seed));
            start       = 1'b1;
            pulses++;
         end
      end
      start = 1'b0;
      if (frames_seen == frames_before) begin
         note_timeout("frame_done");
      end else begin
         if (pix_seen - pix_before != NPIX) begin
            $display("ERROR at %0t: frame gave %0d pixel strobes, expected %0d",
                     $time, pix_seen - pix_before, NPIX);
            proto_errors++;
         end
         if (pulses != extra_starts) begin
            $display("ERROR at %0t: only %0d of %0d start strobes given while busy",
                     $time, pulses, extra_starts);
            proto_errors++;
         end
         cycles = 0;
         while (busy && (cycles < BUSY_TIMEOUT)) begin
            @(negedge clk);
            cycles++;
         end
         if (busy) begin
            note_timeout("busy to fall");
         end else begin
            repeat (5) @(negedge clk);    // Idle gap, nothing may follow the frame
            if ((frames_seen != frames_before + 1) || (pix_seen != pix_before + NPIX)) begin
               $display("ERROR at %0t: strobes seen after the frame ended", $time);
               proto_errors++;
            end
         end
      end
   endtask

   initial begin
      logic signed [WIDTH-1:0] r_re;
      logic signed [WIDTH-1:0] r_im;
      logic signed [WIDTH-1:0] r_step;
      int                      k;
      seed        = 32'h9f8f_7396;
      n_rst       = 1'b0;
      start       = 1'b0;
      c_re_origin = '0;
      c_im_origin = '0;
      c_step      = '0;
      repeat (3) @(negedge clk);       // Reset over 3 rising edges
      n_rst = 1'b1;
      repeat (10) @(negedge clk);
      if (busy || pixel_valid || frame_done) begin
         $display("ERROR at %0t: outputs not idle after reset", $time);
         proto_errors++;
      end
      run_frame(ORG_RE, ORG_IM, STEP, -1, 0);
      run_frame(ZERO, ZERO, ZERO, MAX_ITER, 0);   // c = 0 never escapes
      run_frame(THREE, ZERO, ZERO, 1, 0);         // z = 3 after one step, then escapes
      run_frame(ORG_RE, ORG_IM, STEP, -1, 8);     // Start strobes while busy
      for (k = 0; k < 4; k++) begin
         // Origin in [-2, 0) x [-1.2, -0.2), step up to 0.25
         r_re   = WIDTH'(-2048 + ($random(seed) & 2047));
         r_im   = WIDTH'(-1229 + ($random(seed) & 1023));
         r_step = WIDTH'(1 + ($random(seed) & 255));
         run_frame(r_re, r_im, r_step, -1, 0);
      end
      $display("Frames %0d, pixels %0d, value errors %0d, protocol errors %0d",
               frames_seen, pix_seen, value_errors, proto_errors);
      if (!timed_out && (value_errors == 0) && (proto_errors == 0)) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
hdl/mandel_pkg.sv
hdl/z_step.sv
hdl/pixel_calculator.sv
hdl/scan_counter.sv
hdl/render_fsm.sv
hdl/mandel_top.sv
test/tb_mandel.sv
